//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [15:0] data_word_t;                 // Bus and data word

    // Register offsets within the device
    typedef enum logic [3:0] {
        tx_data   = 4'h0,                             // Word write, two characters
        rx_data   = 4'h1,                             // Received word, pops the FIFO
        tx_status = 4'h2,
        rx_status = 4'h3,
        tx_byte   = 4'h4                              // Single character write
    } reg_offset_t;

    // Raw offset so that unmapped values can be driven as well
    typedef struct packed {
        logic       device_select;
        logic [3:0] offset;
        logic       read_req;
        logic       write_req;
        data_word_t wdata;
    } bus_req_t;

    typedef struct packed {
        data_word_t data;
        logic       byte_mode;                        // Send only the low byte
    } tx_entry_t;

    typedef struct packed {
        data_word_t data;
        logic       padded;                           // High byte filled after timeout
    } rx_entry_t;

    typedef struct packed {
        logic [11:0] reserved;
        logic        full;
        logic        empty;
        logic        busy;
        logic        unused;
    } tx_status_t;

    typedef struct packed {
        logic [11:0] reserved;
        logic        full;
        logic        empty;
        logic        available;
        logic        padded;                          // Head word was padded
    } rx_status_t;

    localparam int CHAR_BITS       = 8;               // Data bits per character
    localparam int FRAME_BITS      = 10;              // Start, 8 data, stop
    localparam int RX_TIMEOUT_BITS = 31;              // Bit periods to wait for 2nd char

    localparam data_word_t UNMAPPED_READ = 16'hFFFF;  // Pull-up value of the bus

endpackage

`default_nettype wire

//--- logic/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
    parameter type entry_t    = logic,
    parameter int  fifo_depth = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  entry_t push_entry,
    input  logic   pop,
    output entry_t head,        // Oldest entry
    output logic   empty,
    output logic   full
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    entry_t           mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;   // Tail, next free slot
    logic [ptr_w-1:0] rd_ptr;   // Head slot
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap also for depths that are not a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(fifo_depth));
    assign do_push = push && !full;     // Dropped when full
    assign do_pop  = pop && !empty;     // No effect when empty
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither, level unchanged
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_baud_gen.sv
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen #(
    parameter int baud_div = 10416      // Cycles per bit minus one
) (
    input  logic clk,
    input  logic reset,
    output logic bit_boundary,          // Start of each bit period
    output logic sample_point           // Middle of each bit period
);

    localparam int cnt_w = (baud_div > 0) ? $clog2(baud_div + 1) : 1;

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count        <= '0;
            bit_boundary <= 1'b0;
            sample_point <= 1'b0;
        end else begin
            bit_boundary <= (count == cnt_w'(baud_div));
            sample_point <= (count == cnt_w'(baud_div / 2)) && (count != cnt_w'(baud_div));
            if (count == cnt_w'(baud_div)) begin
                count <= '0;            // Wrap, new bit period
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      bit_boundary,
    input  tx_entry_t fifo_head,
    input  logic      fifo_empty,
    output logic      fifo_pop,
    output logic      busy,
    output logic      uart_tx       // Serial line, idles high
);

    localparam int frame_w = 2 * FRAME_BITS;
    localparam int idx_w   = $clog2(frame_w);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_wait_boundary,
        st_send_char0,
        st_send_char1,
        st_complete_byte
    } tx_state_t;

    tx_state_t          state;
    logic [frame_w-1:0] frame;      // Both characters, sent from bit 0 up
    logic [idx_w-1:0]   bit_idx;
    logic               byte_mode_q;
    logic               word_done;

    // Entry stays in the FIFO until its last bit has gone out
    assign word_done = (state == st_send_char1) && bit_boundary
                       && (bit_idx == idx_w'(frame_w - 1));
    assign fifo_pop  = word_done || (state == st_complete_byte);
    assign busy      = (state != st_idle);

    // Frame image taken from the FIFO head
    always_ff @(posedge clk) begin
        if (state == st_load) begin
            byte_mode_q <= fifo_head.byte_mode;
            if (fifo_head.byte_mode) begin
                frame <= {{FRAME_BITS{1'b0}}, 1'b1, fifo_head.data[CHAR_BITS-1:0], 1'b0};
            end else begin
                frame <= {1'b1, fifo_head.data[2*CHAR_BITS-1:CHAR_BITS], 1'b0,
                          1'b1, fifo_head.data[CHAR_BITS-1:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    uart_tx <= 1'b1;
                    if (!fifo_empty) state <= st_load;
                end
                st_load: begin
                    bit_idx <= '0;
                    state   <= st_wait_boundary;
                end
                st_wait_boundary: begin
                    // Align the start bit to a full bit period
                    if (bit_boundary) state <= st_send_char0;
                end
                st_send_char0: begin
                    if (bit_boundary) begin
                        uart_tx <= frame[bit_idx];
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == idx_w'(FRAME_BITS - 1)) begin
                            state <= byte_mode_q ? st_complete_byte : st_send_char1;
                        end
                    end
                end
                st_send_char1: begin
                    if (bit_boundary) begin
                        uart_tx <= frame[bit_idx];
                        bit_idx <= bit_idx + 1'b1;
                        if (word_done) state <= st_idle;    // Stop bit still on the line
                    end
                end
                st_complete_byte: state <= st_idle;         // Pop cycle of a byte entry
                default:          state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      uart_rx,      // Serial line from the far end
    input  logic      sample_point,
    output logic      fifo_push,
    output rx_entry_t fifo_entry
);

    localparam int to_w  = $clog2(RX_TIMEOUT_BITS + 1);
    localparam int bit_w = $clog2(CHAR_BITS);

    typedef enum logic [2:0] {
        st_idle,
        st_start_bit,
        st_data_bits,
        st_stop_bit,
        st_assemble
    } rx_state_t;

    rx_state_t              state;
    logic                   sync1;
    logic                   sync2;
    logic                   sync3;
    logic                   start_det;      // Falling edge on the line
    logic [CHAR_BITS-1:0]   shift;
    logic [CHAR_BITS-1:0]   char0;          // Low byte waiting for its partner
    logic                   char0_valid;
    logic [bit_w-1:0]       bit_idx;
    logic [to_w-1:0]        timeout_cnt;
    logic                   stop_sample;
    logic                   timeout_hit;

    assign stop_sample = (state == st_stop_bit) && sample_point;  // Stop bit not checked
    assign timeout_hit = (state == st_assemble) && !start_det && sample_point
                         && (timeout_cnt == to_w'(RX_TIMEOUT_BITS - 1));

    // Three flops against metastability, then edge detect
    always_ff @(posedge clk) begin
        if (reset) begin
            sync1     <= 1'b1;
            sync2     <= 1'b1;
            sync3     <= 1'b1;
            start_det <= 1'b0;
        end else begin
            sync1     <= uart_rx;
            sync2     <= sync1;
            sync3     <= sync2;
            start_det <= sync3 && !sync2;
        end
    end

    // Character and word payload
    always_ff @(posedge clk) begin
        if ((state == st_data_bits) && sample_point) shift <= {sync2, shift[CHAR_BITS-1:1]};
        if (stop_sample && !char0_valid) char0 <= shift;
        if (stop_sample && char0_valid) begin
            fifo_entry <= '{data: {shift, char0}, padded: 1'b0};
        end else if (timeout_hit) begin
            fifo_entry <= '{data: {{CHAR_BITS{1'b0}}, char0}, padded: 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            char0_valid <= 1'b0;
            bit_idx     <= '0;
            timeout_cnt <= '0;
            fifo_push   <= 1'b0;
        end else begin
            fifo_push <= (stop_sample && char0_valid) || timeout_hit;
            case (state)
                st_idle: begin
                    char0_valid <= 1'b0;    // Word done or abandoned
                    if (start_det) state <= st_start_bit;
                end
                st_start_bit: begin
                    if (sample_point) begin
                        bit_idx <= '0;
                        state   <= sync2 ? st_idle : st_data_bits;  // High means glitch
                    end
                end
                st_data_bits: begin
                    if (sample_point) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_w'(CHAR_BITS - 1)) state <= st_stop_bit;
                    end
                end
                st_stop_bit: begin
                    if (sample_point) begin
                        if (char0_valid) begin
                            state <= st_idle;       // Full word pushed
                        end else begin
                            char0_valid <= 1'b1;
                            timeout_cnt <= '0;
                            state       <= st_assemble;
                        end
                    end
                end
                st_assemble: begin
                    if (start_det) begin
                        state <= st_start_bit;      // Second character begins
                    end else if (timeout_hit) begin
                        state <= st_idle;           // Padded word pushed
                    end else if (sample_point) begin
                        timeout_cnt <= timeout_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_regs.sv
`timescale 1ns/100ps
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   bus,
    output data_word_t rdata,
    output logic       tx_push,
    output tx_entry_t  tx_entry,
    input  logic       tx_empty,
    input  logic       tx_full,
    input  logic       tx_busy,
    output logic       rx_pop,
    input  rx_entry_t  rx_head,
    input  logic       rx_empty,
    input  logic       rx_full
);

    logic       wr_hit;
    logic       rd_hit;
    tx_status_t tx_status_d;
    tx_status_t tx_status_q;
    rx_status_t rx_status_d;
    rx_status_t rx_status_q;
    data_word_t rx_data_q;      // Head word, zero when empty

    assign wr_hit = bus.device_select && bus.write_req;
    assign rd_hit = bus.device_select && bus.read_req;

    // Strobes last as long as the request, one cycle on this bus
    assign tx_push  = wr_hit && ((bus.offset == tx_data) || (bus.offset == tx_byte));
    assign tx_entry = '{data: bus.wdata, byte_mode: (bus.offset == tx_byte)};
    assign rx_pop   = rd_hit && (bus.offset == rx_data);

    always_comb begin
        tx_status_d       = '0;
        tx_status_d.full  = tx_full;
        tx_status_d.empty = tx_empty;
        tx_status_d.busy  = tx_busy;

        rx_status_d           = '0;
        rx_status_d.full      = rx_full;
        rx_status_d.empty     = rx_empty;
        rx_status_d.available = !rx_empty;
        rx_status_d.padded    = !rx_empty && rx_head.padded;  // Flag of the head word only
    end

    // Reads see the state of the previous edge
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_status_q <= '{reserved: '0, full: 1'b0, empty: 1'b1, busy: 1'b0, unused: 1'b0};
            rx_status_q <= '{reserved: '0, full: 1'b0, empty: 1'b1, available: 1'b0,
                             padded: 1'b0};
            rx_data_q   <= '0;
        end else begin
            tx_status_q <= tx_status_d;
            rx_status_q <= rx_status_d;
            rx_data_q   <= rx_empty ? '0 : rx_head.data;
        end
    end

    always_comb begin
        rdata = UNMAPPED_READ;  // Idle bus and write-only offsets
        if (rd_hit) begin
            case (bus.offset)
                rx_data:   rdata = rx_data_q;
                tx_status: rdata = tx_status_q;
                rx_status: rdata = rx_status_q;
                default:   rdata = UNMAPPED_READ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_controller.sv
`timescale 1ns/100ps
`default_nettype none

module uart_controller import uart_pkg::*; #(
    parameter int baud_div   = 10416,   // 9600 baud at 100 MHz
    parameter int fifo_depth = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   bus,
    output data_word_t rdata,
    output logic       uart_tx,
    input  logic       uart_rx
);

    logic      tx_push;
    tx_entry_t tx_entry;
    tx_entry_t tx_head;
    logic      tx_empty;
    logic      tx_full;
    logic      tx_pop;
    logic      tx_busy;
    logic      rx_push;
    rx_entry_t rx_entry;        // Word from the receiver
    rx_entry_t rx_head;
    logic      rx_empty;
    logic      rx_full;
    logic      rx_pop;
    logic      bit_boundary;
    logic      sample_point;

    uart_regs regs_i (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .rdata    (rdata),
        .tx_push  (tx_push),
        .tx_entry (tx_entry),
        .tx_empty (tx_empty),
        .tx_full  (tx_full),
        .tx_busy  (tx_busy),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_empty (rx_empty),
        .rx_full  (rx_full)
    );

    uart_fifo #(.entry_t(tx_entry_t), .fifo_depth(fifo_depth)) tx_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .push       (tx_push),
        .push_entry (tx_entry),
        .pop        (tx_pop),
        .head       (tx_head),
        .empty      (tx_empty),
        .full       (tx_full)
    );

    uart_fifo #(.entry_t(rx_entry_t), .fifo_depth(fifo_depth)) rx_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .push       (rx_push),
        .push_entry (rx_entry),
        .pop        (rx_pop),
        .head       (rx_head),
        .empty      (rx_empty),
        .full       (rx_full)
    );

    // Shared bit timing for both directions
    uart_baud_gen #(.baud_div(baud_div)) baud_gen_i (
        .clk          (clk),
        .reset        (reset),
        .bit_boundary (bit_boundary),
        .sample_point (sample_point)
    );

    uart_tx tx_i (
        .clk          (clk),
        .reset        (reset),
        .bit_boundary (bit_boundary),
        .fifo_head    (tx_head),
        .fifo_empty   (tx_empty),
        .fifo_pop     (tx_pop),
        .busy         (tx_busy),
        .uart_tx      (uart_tx)
    );

    uart_rx rx_i (
        .clk          (clk),
        .reset        (reset),
        .uart_rx      (uart_rx),
        .sample_point (sample_point),
        .fifo_push    (rx_push),
        .fifo_entry   (rx_entry)
    );

endmodule

`default_nettype wire

//--- testbench/uart_controller_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module uart_controller_asserts import uart_pkg::*; (
    input logic       clk,
    input logic       reset,
    input bus_req_t   bus,
    input data_word_t rdata,
    input logic       uart_tx,
    input logic       tx_busy,
    input logic       rx_push     // RX FIFO push strobe
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Line rests high outside a transfer
    line_idle_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> uart_tx)
        else begin
            fail_count++;
            $error("uart_tx low while the transmitter is idle");
        end

    // Bus reads back the pull-up value when not read
    rdata_idle: assert property (@(posedge clk) disable iff (reset)
        !(bus.device_select && bus.read_req) |-> (rdata == 16'hFFFF))
        else begin
            fail_count++;
            $error("rdata not 0xFFFF without a read request");
        end

    rx_push_single: assert property (@(posedge clk) disable iff (reset) rx_push |=> !rx_push)
        else begin
            fail_count++;
            $error("RX FIFO push held for two cycles");
        end

endmodule

bind uart_controller uart_controller_asserts asserts_i (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus),
    .rdata   (rdata),
    .uart_tx (uart_tx),
    .tx_busy (tx_busy),
    .rx_push (rx_push)
);

`default_nettype wire

//--- testbench/uart_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_controller_tb import uart_pkg::*; ();

    localparam int baud_div    = 15;           // Short bit period for simulation
    localparam int fifo_depth  = 8;
    localparam int num_bursts  = 20;           // Random loopback bursts
    localparam int bit_cycles  = baud_div + 1;
    localparam int clk_period  = 10;
    // Random bursts plus the TX full burst, doubled for margin
    localparam int watchdog_ns = (num_bursts + 1) * 16 * FRAME_BITS * bit_cycles
                                 * clk_period * 2;
    localparam logic [3:0] unmapped_offsets [4] = '{4'h0, 4'h4, 4'h5, 4'h9};

    logic       clk;
    logic       reset;
    bus_req_t   bus;
    data_word_t rdata;
    logic       tx_line;
    logic       rx_line;
    logic       loop_en;                       // Line held idle until reset is over
    int         seed;
    logic [7:0] char_q [$];                    // Characters in line order
    rx_entry_t  exp_q [$];                     // Words the receiver should produce

    assign rx_line = loop_en ? tx_line : 1'b1; // Loopback

    uart_controller #(.baud_div(baud_div), .fifo_depth(fifo_depth)) dut_i (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus),
        .rdata   (rdata),
        .uart_tx (tx_line),
        .uart_rx (rx_line)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s expected 0x%04h got 0x%04h", name, exp, got));
        end
    endtask

    task automatic check_tx_status(input tx_status_t got, input tx_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] tx_status expected 0x%04h got 0x%04h", exp, got));
        end
    endtask

    task automatic check_rx_status(input rx_status_t got, input rx_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] rx_status expected 0x%04h got 0x%04h", exp, got));
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got));
        end
    endtask

    // One request cycle, then two idle cycles
    task automatic bus_write(input logic [3:0] addr, input data_word_t data);
        @(negedge clk);
        bus = '{device_select: 1'b1, offset: addr, read_req: 1'b0, write_req: 1'b1, wdata: data};
        @(negedge clk);
        bus = '0;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [3:0] addr, output data_word_t data);
        @(negedge clk);
        bus = '{device_select: 1'b1, offset: addr, read_req: 1'b1, write_req: 1'b0, wdata: '0};
        #(clk_period / 4);                     // Mid low phase, rdata settled
        data = rdata;
        @(negedge clk);
        bus = '0;
        @(negedge clk);
    endtask

    task automatic model_entry(input data_word_t data, input logic byte_mode);
        char_q.push_back(data[7:0]);           // Low byte always goes first
        if (!byte_mode) char_q.push_back(data[15:8]);
    endtask

    // Pair the character stream into words, low byte first
    task automatic build_words();
        rx_entry_t w;
        while (char_q.size() >= 2) begin
            w.data[7:0]  = char_q.pop_front();
            w.data[15:8] = char_q.pop_front();
            w.padded     = 1'b0;
            exp_q.push_back(w);
        end
        if (char_q.size() == 1) begin
            w.data   = {8'h00, char_q.pop_front()};
            w.padded = 1'b1;                   // Lone character, receiver times out
            exp_q.push_back(w);
        end
    endtask

    task automatic wait_tx_drained();
        data_word_t rd;
        tx_status_t st;
        do begin
            bus_read(tx_status, rd);
            st = rd;
        end while (!(st.empty && !st.busy));
        repeat (40 * bit_cycles) @(negedge clk);   // Last stop bit and RX timeout
    endtask

    task automatic drain_rx();
        data_word_t rd;
        rx_status_t st;
        rx_status_t exp_st;
        rx_entry_t  w;
        bus_read(rx_status, rd);
        st = rd;
        while (st.available) begin
            if (exp_q.size() == 0) report_failure("Receiver produced an unexpected extra word");
            w                = exp_q[0];
            exp_st           = '0;
            exp_st.available = 1'b1;
            exp_st.padded    = w.padded;
            exp_st.full      = (exp_q.size() == fifo_depth);
            check_rx_status(st, exp_st);
            bus_read(rx_data, rd);             // Pops the head word
            check_word("rx_data", rd, w.data);
            void'(exp_q.pop_front());
            bus_read(rx_status, rd);
            st = rd;
        end
        if (exp_q.size() != 0) report_failure("Receiver produced fewer words than expected");
        check_rx_status(st, 16'h0004);
    endtask

    initial begin
        data_word_t rd;
        data_word_t data;
        logic       byte_mode;
        int         n_entries;
        seed    = 32'h2027;
        reset   = 1'b1;
        bus     = '0;
        loop_en = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        loop_en = 1'b1;

        // Reset state
        bus_read(tx_status, rd);
        check_tx_status(rd, 16'h0004);
        bus_read(rx_status, rd);
        check_rx_status(rd, 16'h0004);
        check_line("uart_tx", tx_line, 1'b1);

        // Write-only and unmapped offsets, then RX data while empty
        foreach (unmapped_offsets[i]) begin
            bus_read(unmapped_offsets[i], rd);
            check_word($sformatf("rdata at offset %0d", unmapped_offsets[i]), rd, 16'hFFFF);
        end
        bus_read(rx_data, rd);
        check_word("rx_data when empty", rd, 16'h0000);

        for (int b = 0; b < num_bursts; b++) begin
            n_entries = ($random(seed) & 3) + 1;    // 1 to 4 entries
            for (int e = 0; e < n_entries; e++) begin
                data      = 16'($random(seed));
                byte_mode = 1'($random(seed));
                bus_write(byte_mode ? tx_byte : tx_data, data);
                model_entry(data, byte_mode);
            end
            build_words();
            wait_tx_drained();
            drain_rx();
        end

        // Nine byte entries into an 8-deep TX FIFO
        for (int e = 0; e < fifo_depth + 1; e++) begin
            data = 16'($random(seed));
            bus_write(tx_byte, data);
            if (e < fifo_depth) model_entry(data, 1'b1);   // Ninth one is dropped
        end
        bus_read(tx_status, rd);
        check_tx_status(rd, 16'h000A);         // Full and busy
        build_words();
        wait_tx_drained();
        drain_rx();

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("Bound assertions reported errors");
        end
    end

    // Stop as soon as a bound assertion fails
    initial begin
        wait (dut_i.asserts_i.fail_count != 0);
        report_failure("A bound assertion failed during the run");
    end

    initial begin
        #(watchdog_ns);
        report_failure($sformatf("Timeout after %0d ns with tests still running", watchdog_ns));
    end

endmodule

`default_nettype wire

//--- flist.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_controller.sv
testbench/uart_controller_asserts.sv
testbench/uart_controller_tb.sv

//--- run.sh
#!/bin/sh
# Build, run, and decide the result from the log
rm -f sim.log &&
verilator --binary --timing --assert --top-module uart_controller_tb -f flist.f -o uart_sim &&
./obj_dir/uart_sim +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "Simulation finished: PASS" sim.log && echo "run.sh: passed" || { echo "run.sh: failed"; exit 1; }
